// ==== src.f ====
common/lcd_pkg.sv
rtl/text_buf.sv
lcd/lcd_msg_seq.sv
lcd/lcd_ctrl.sv
rtl/lcd_sys_top.sv
tests/lcd_sys_assert.sv
tests/lcd_sys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module lcd_sys_tb -f src.f \
	-o lcd_sys_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/lcd_sys_sim > sim.log 2>&1
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

// ==== tests/lcd_sys_tb.sv ====
module lcd_sys_tb
	import lcd_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS   = 3;
	localparam int INIT_CYC   = PWRUP_CYC + 4 * CMD_PULSE_CYC + 2 * INIT_GAP_CYC
		+ CLEAR_GAP_CYC + ENTRY_GAP_CYC;
	localparam int MARGIN_CYC = 4000;  // fills, idle waits, sequencer overhead
	localparam int ROW_CYC    = INIT_CYC + 2 * NUM_WRITES * WR_CYCLE_CYC + MARGIN_CYC;

	// line 1 then line 2
	localparam logic [8*NUM_CHARS-1:0] FIXED_TEXT = {"HD44780 ON 8 BIT", "TWO LINES OF 16 "};

	// init bytes worked out by hand from cfg
	typedef struct packed {
		logic [CFG_W-1:0] cfg;
		logic             rand_text;  // LFSR text instead of the fixed string
		logic             restart;    // second message after a partial rewrite
		logic [7:0]       exp_func;
		logic [7:0]       exp_disp;
		logic [7:0]       exp_entry;
	} row_t;

	logic             clk = 1'b0;
	logic             rst;
	logic             buf_wr;
	char_addr_t       buf_addr;
	logic [7:0]       buf_char;
	logic [CFG_W-1:0] cfg;
	logic             start;
	logic             e;
	logic             rs;
	logic             rw;
	logic [7:0]       lcd_data;
	logic             busy;
	logic             seq_busy;
	logic             done;

	row_t        rows [NUM_ROWS];
	logic [7:0]  shadow [NUM_CHARS];  // host copy of the buffer
	logic [31:0] lfsr = 32'hf9b;
	lcd_word_t   word_q [$];          // {rs, rw, data} at each falling e
	int          pulse_q [$];         // e high cycles, same order
	int          high_cyc;
	int          done_cnt;

	lcd_sys_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.buf_wr   (buf_wr),
		.buf_addr (buf_addr),
		.buf_char (buf_char),
		.cfg      (cfg),
		.start    (start),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.busy     (busy),
		.seq_busy (seq_busy),
		.done     (done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// bus monitor, a word is taken in the first cycle with e low again
	always @(posedge clk) begin
		if (rst) begin
			word_q.delete();
			pulse_q.delete();
			high_cyc = 0;
			done_cnt = 0;
		end else begin
			if (done) begin
				done_cnt++;
			end
			if (e) begin
				high_cyc++;
			end else if (high_cyc != 0) begin
				word_q.push_back({rs, rw, lcd_data});
				pulse_q.push_back(high_cyc);
				high_cyc = 0;
			end
		end
	end

	initial begin
		#(NUM_ROWS * ROW_CYC * CLK_PERIOD);
		$display("watchdog expired before the last row finished");
		$display("*** FAILED ***");
		$fatal(1, "watchdog timeout");
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected k-th word of a message
	function automatic lcd_word_t message_word(input int k);
		if (k == 0) return {2'b00, CMD_DDRAM_LINE1};
		if (k == LINE_CHARS + 1) return {2'b00, CMD_DDRAM_LINE2};
		if (k <= LINE_CHARS) return {2'b10, shadow[k - 1]};
		return {2'b10, shadow[k - 2]};
	endfunction

	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input lcd_word_t got, input lcd_word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic write_char(input char_addr_t addr, input logic [7:0] ch);
		buf_wr   <= 1'b1;
		buf_addr <= addr;
		buf_char <= ch;
		@(posedge clk);
	endtask

	task automatic pulse_start();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic await_init(input int limit);
		int n;
		n = 0;
		while (busy) begin
			@(posedge clk);
			n++;
			if (n > limit) begin
				$display("busy did not fall after init at %0t", $time);
				abort_run();
			end
		end
	endtask

	task automatic await_words(input int count, input int limit);
		int n;
		n = 0;
		while (word_q.size() < count) begin
			@(posedge clk);
			n++;
			if (n > limit) begin
				$display("too few bus writes seen after start at %0t", $time);
				abort_run();
			end
		end
	endtask

	task automatic await_done(input int limit);
		int n;
		n = 0;
		while (!done) begin
			@(posedge clk);
			n++;
			if (n > limit) begin
				$display("done never pulsed for the message at %0t", $time);
				abort_run();
			end
		end
	endtask

	task automatic fill_text(input logic rand_text);
		logic [7:0] ch;
		for (int i = 0; i < NUM_CHARS; i++) begin
			if (rand_text) begin
				ch = 8'h30 + rand_bits(6);  // printable range
			end else begin
				ch = FIXED_TEXT[8*(NUM_CHARS-1-i) +: 8];
			end
			shadow[i] = ch;
			write_char(char_addr_t'(i), ch);
		end
		buf_wr <= 1'b0;
	endtask

	task automatic rewrite_some();
		char_addr_t addr;
		logic [7:0] ch;
		for (int j = 0; j < 6; j++) begin
			addr = char_addr_t'(rand_bits(5));
			ch   = 8'h61 + rand_bits(4);  // lower case letters
			shadow[addr] = ch;
			write_char(addr, ch);
		end
		buf_wr <= 1'b0;
	endtask

	// one message, with a start pulse that must be ignored halfway
	task automatic send_and_check(input int first, input int dones);
		pulse_start();
		await_words(first + 3, 4 * WR_CYCLE_CYC);
		check_bit("seq_busy", seq_busy, 1'b1);
		pulse_start();
		await_done(NUM_WRITES * (WR_CYCLE_CYC + 8));
		check_count("words at done", word_q.size(), first + NUM_WRITES);
		check_bit("busy at done", busy, 1'b0);
		repeat (WR_CYCLE_CYC) @(posedge clk);  // room for a stray write
		check_count("done pulses", done_cnt, dones);
		check_count("message words", word_q.size(), first + NUM_WRITES);
		for (int k = 0; k < NUM_WRITES; k++) begin
			check_word($sformatf("write %0d word", k), word_q[first + k], message_word(k));
			check_count($sformatf("write %0d e high", k), pulse_q[first + k], WR_HIGH_CYC);
		end
	endtask

	task automatic run_row(input row_t row);
		lcd_word_t exp_init [4];
		exp_init[0] = {2'b00, row.exp_func};
		exp_init[1] = {2'b00, row.exp_disp};
		exp_init[2] = {2'b00, 8'h01};
		exp_init[3] = {2'b00, row.exp_entry};
		cfg <= row.cfg;
		apply_reset();
		@(posedge clk);
		check_word("rs/rw/lcd_data", {rs, rw, lcd_data}, '0);
		check_bit("e", e, 1'b0);
		check_bit("busy", busy, 1'b1);
		check_bit("seq_busy", seq_busy, 1'b0);
		check_bit("done", done, 1'b0);
		await_init(INIT_CYC + 16);
		check_count("init words", word_q.size(), 4);
		for (int i = 0; i < 4; i++) begin
			check_word($sformatf("init %0d word", i), word_q[i], exp_init[i]);
			check_count($sformatf("init %0d e high", i), pulse_q[i], CMD_PULSE_CYC);
		end
		fill_text(row.rand_text);
		send_and_check(4, 1);
		if (row.restart) begin
			rewrite_some();
			send_and_check(4 + NUM_WRITES, 2);
		end
	endtask

	initial begin
		rst      = 1'b1;
		buf_wr   = 1'b0;
		buf_addr = '0;
		buf_char = 8'h00;
		cfg      = '0;
		start    = 1'b0;
		rows[0]  = '{7'b1011110, 1'b0, 1'b1, 8'h38, 8'h0F, 8'h06};
		rows[1]  = '{7'b0110101, 1'b1, 1'b0, 8'h34, 8'h0D, 8'h05};
		rows[2]  = '{7'b1100011, 1'b1, 1'b1, 8'h3C, 8'h08, 8'h07};
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(rows[r]);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== tests/lcd_sys_assert.sv ====
module lcd_ctrl_assert
	import lcd_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       e,
	input logic       busy,
	input logic       lcd_enable,
	input logic [7:0] lcd_data
);

	logic tracking;  // accepted write still running
	int   busy_cyc;

	always_ff @(posedge clk) begin
		if (rst) begin
			tracking <= 1'b0;
			busy_cyc <= 0;
		end else if (lcd_enable && !busy) begin
			tracking <= 1'b1;
			busy_cyc <= 0;
		end else if (tracking && busy) begin
			busy_cyc <= busy_cyc + 1;
		end else begin
			tracking <= 1'b0;
		end
	end

	// busy is low only in the ready state
	assert property (@(posedge clk) disable iff (rst) !busy |-> !e)
		else $error("e high while the controller is ready");

	assert property (@(posedge clk) disable iff (rst) (lcd_enable && busy) |=> $stable(lcd_data))
		else $error("lcd_data changed after an enable strobe while busy");

	assert property (@(posedge clk) disable iff (rst)
		(tracking && !busy) |-> busy_cyc == WR_CYCLE_CYC)
		else $error("busy fell early after write acceptance");

	assert property (@(posedge clk) disable iff (rst)
		(tracking && busy) |-> busy_cyc < WR_CYCLE_CYC)
		else $error("busy held too long after write acceptance");

endmodule

bind lcd_ctrl lcd_ctrl_assert lcd_ctrl_assert_i (
	.clk        (clk),
	.rst        (rst),
	.e          (e),
	.busy       (busy),
	.lcd_enable (lcd_enable),
	.lcd_data   (lcd_data)
);

// ==== rtl/lcd_sys_top.sv ====
module lcd_sys_top
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             buf_wr,
	input  char_addr_t       buf_addr,
	input  logic [7:0]       buf_char,
	input  logic [CFG_W-1:0] cfg,
	input  logic             start,
	output logic             e,
	output logic             rs,
	output logic             rw,
	output logic [7:0]       lcd_data,
	output logic             busy,
	output logic             seq_busy,
	output logic             done
);

	char_addr_t rd_addr;
	logic [7:0] rd_char;
	logic       lcd_enable;
	lcd_word_t  lcd_word;

	text_buf text_buf_i (
		.clk     (clk),
		.rst     (rst),
		.wr      (buf_wr),
		.wr_addr (buf_addr),
		.wr_char (buf_char),
		.rd_addr (rd_addr),
		.rd_char (rd_char)
	);

	lcd_msg_seq lcd_msg_seq_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.rd_addr    (rd_addr),
		.rd_char    (rd_char),
		.busy       (busy),      // controller busy is the only back-pressure
		.lcd_enable (lcd_enable),
		.lcd_word   (lcd_word),
		.seq_busy   (seq_busy),
		.done       (done)
	);

	lcd_ctrl lcd_ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_word   (lcd_word),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

endmodule

// ==== lcd/lcd_ctrl.sv ====
module lcd_ctrl
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [CFG_W-1:0] cfg,
	input  logic             lcd_enable,
	input  lcd_word_t        lcd_word,
	output logic             e,
	output logic             rs,
	output logic             rw,
	output logic [7:0]       lcd_data,
	output logic             busy
);

	typedef enum logic [1:0] {
		st_pwrup,
		st_init,
		st_ready,
		st_write
	} state_t;

	state_t     state;
	cyc_cnt_t   cnt;        // shared by every timed phase
	logic [1:0] init_step;  // function set, display, clear, entry mode
	logic       in_gap;     // pulse done, waiting out the command

	// init command bytes, cfg fields merged into the fixed bits
	function automatic logic [7:0] init_cmd(input logic [1:0] step,
		input logic [CFG_W-1:0] c);
		logic [7:0] cmd;
		case (step)
			2'd0: cmd = CMD_FUNC_BASE | {4'b0000, c[CFG_LINES], c[CFG_FONT], 2'b00};
			2'd1: cmd = CMD_DISP_BASE | {5'b00000, c[CFG_ON], c[CFG_CURSOR], c[CFG_BLINK]};
			2'd2: cmd = CMD_CLEAR;
			default: cmd = CMD_ENTRY_BASE | {6'b000000, c[CFG_INC], c[CFG_SHIFT]};
		endcase
		return cmd;
	endfunction

	// last count of the e low wait after each init command
	function automatic cyc_cnt_t gap_last(input logic [1:0] step);
		cyc_cnt_t last;
		case (step)
			2'd2: last = cyc_cnt_t'(CLEAR_GAP_CYC - 1);
			2'd3: last = cyc_cnt_t'(ENTRY_GAP_CYC - 1);
			default: last = cyc_cnt_t'(INIT_GAP_CYC - 1);
		endcase
		return last;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_pwrup;
			cnt       <= '0;
			init_step <= 2'd0;
			in_gap    <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= 8'h00;
			busy      <= 1'b1;
		end else begin
			case (state)
				st_pwrup: begin
					if (cnt == cyc_cnt_t'(PWRUP_CYC - 1)) begin
						cnt       <= '0;
						init_step <= 2'd0;
						in_gap    <= 1'b0;
						e         <= 1'b1;  // first command, function set
						lcd_data  <= init_cmd(2'd0, cfg);
						state     <= st_init;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				st_init: begin
					if (!in_gap) begin
						if (cnt == cyc_cnt_t'(CMD_PULSE_CYC - 1)) begin
							cnt    <= '0;
							e      <= 1'b0;  // display latches on this edge
							in_gap <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (cnt == gap_last(init_step)) begin
						cnt    <= '0;
						in_gap <= 1'b0;
						if (init_step == 2'd3) begin
							lcd_data <= 8'h00;
							busy     <= 1'b0;  // init complete
							state    <= st_ready;
						end else begin
							init_step <= init_step + 2'd1;
							e         <= 1'b1;
							lcd_data  <= init_cmd(init_step + 2'd1, cfg);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				st_ready: begin
					// busy is always low here
					if (lcd_enable) begin
						rs       <= lcd_word[BUS_W-1];
						rw       <= lcd_word[BUS_W-2];
						lcd_data <= lcd_word[7:0];
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= st_write;
					end
				end

				st_write: begin
					cnt <= cnt + 1'b1;
					if (cnt == cyc_cnt_t'(WR_SETUP_CYC - 1)) begin
						e <= 1'b1;
					end
					if (cnt == cyc_cnt_t'(WR_SETUP_CYC + WR_HIGH_CYC - 1)) begin
						e <= 1'b0;
					end
					if (cnt == cyc_cnt_t'(WR_CYCLE_CYC - 1)) begin
						// bus back to idle, next write may come
						cnt      <= '0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
						busy     <= 1'b0;
						state    <= st_ready;
					end
				end

				default: begin
					state <= st_pwrup;
				end
			endcase
		end
	end

endmodule

// ==== lcd/lcd_msg_seq.sv ====
module lcd_msg_seq
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	output char_addr_t rd_addr,
	input  logic [7:0] rd_char,
	input  logic       busy,
	output logic       lcd_enable,
	output lcd_word_t  lcd_word,
	output logic       seq_busy,
	output logic       done
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,   // buffer read in flight
		st_send,
		st_wait
	} state_t;

	state_t    state;
	seq_pos_t  pos;        // 0 line-1 cmd, 1..16 chars, 17 line-2 cmd, 18..33 chars
	seq_pos_t  char_idx;
	logic      pending;    // strobed, busy not yet seen
	logic      is_cmd;
	logic      can_send;
	lcd_word_t next_word;

	// buffer index skips the address command slots
	assign char_idx = (pos > seq_pos_t'(LINE_CHARS)) ? pos - seq_pos_t'(2)
		: pos - seq_pos_t'(1);
	assign rd_addr  = char_idx[CHAR_ADDR_W-1:0];

	assign is_cmd   = (pos == '0) || (pos == seq_pos_t'(LINE_CHARS + 1));
	assign can_send = !pending && !busy;

	always_comb begin
		if (!is_cmd) begin
			next_word = {2'b10, rd_char};        // data write, rs 1
		end else if (pos == '0) begin
			next_word = {2'b00, CMD_DDRAM_LINE1};
		end else begin
			next_word = {2'b00, CMD_DDRAM_LINE2};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			pos        <= '0;
			pending    <= 1'b0;
			lcd_enable <= 1'b0;
			seq_busy   <= 1'b0;
			done       <= 1'b0;
		end else begin
			lcd_enable <= 1'b0;
			done       <= 1'b0;
			if (pending && busy) begin
				pending <= 1'b0;  // controller took the word
			end

			case (state)
				st_idle: begin
					if (start) begin
						pos      <= '0;
						seq_busy <= 1'b1;
						state    <= st_read;
					end
				end

				st_read: begin
					state <= st_send;  // rd_char valid next cycle
				end

				st_send: begin
					if (can_send) begin
						lcd_enable <= 1'b1;
						pending    <= 1'b1;
						state      <= st_wait;
					end
				end

				st_wait: begin
					// write finished once busy is back low
					if (can_send) begin
						if (pos == seq_pos_t'(NUM_WRITES - 1)) begin
							seq_busy <= 1'b0;
							done     <= 1'b1;
							state    <= st_idle;
						end else begin
							pos   <= pos + 1'b1;
							state <= st_read;
						end
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// word is loaded with the strobe
	always_ff @(posedge clk) begin
		if (state == st_send && can_send) begin
			lcd_word <= next_word;
		end
	end

endmodule

// ==== rtl/text_buf.sv ====
module text_buf
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,
	input  char_addr_t wr_addr,
	input  logic [7:0] wr_char,
	input  char_addr_t rd_addr,
	output logic [7:0] rd_char
);

	// one byte per display position, line 1 first
	logic [7:0] mem [NUM_CHARS];

	// host side, blank screen after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CHARS; i++) begin
				mem[i] <= CHAR_SPACE;
			end
		end else if (wr) begin
			mem[wr_addr] <= wr_char;
		end
	end

	// sequencer side, one cycle latency
	// same-address write in this cycle still returns the old byte
	always_ff @(posedge clk) begin
		rd_char <= mem[rd_addr];
	end

endmodule

// ==== common/lcd_pkg.sv ====
package lcd_pkg;

	// clock and timing, all waits in microseconds
	localparam int CLK_PER_US   = 15;  // 15 MHz system clock
	localparam int PWRUP_US     = 500;
	localparam int CMD_PULSE_US = 10;
	localparam int INIT_GAP_US  = 50;  // after function set and display control
	localparam int CLEAR_GAP_US = 200;
	localparam int ENTRY_GAP_US = 100;
	localparam int WR_SETUP_US  = 1;   // e low lead of a write
	localparam int WR_HIGH_US   = 13;
	localparam int WR_CYCLE_US  = 50;

	// the same waits in clock cycles
	localparam int PWRUP_CYC     = PWRUP_US * CLK_PER_US;
	localparam int CMD_PULSE_CYC = CMD_PULSE_US * CLK_PER_US;
	localparam int INIT_GAP_CYC  = INIT_GAP_US * CLK_PER_US;
	localparam int CLEAR_GAP_CYC = CLEAR_GAP_US * CLK_PER_US;
	localparam int ENTRY_GAP_CYC = ENTRY_GAP_US * CLK_PER_US;
	localparam int WR_SETUP_CYC  = WR_SETUP_US * CLK_PER_US;
	localparam int WR_HIGH_CYC   = WR_HIGH_US * CLK_PER_US;
	localparam int WR_CYCLE_CYC  = WR_CYCLE_US * CLK_PER_US;

	localparam int CNT_W = $clog2(PWRUP_CYC + 1); // power-up is the longest wait
	typedef logic [CNT_W-1:0] cyc_cnt_t;

	// HD44780 command codes
	localparam logic [7:0] CMD_FUNC_BASE   = 8'h30; // 8-bit bus, N and F below
	localparam logic [7:0] CMD_DISP_BASE   = 8'h08;
	localparam logic [7:0] CMD_CLEAR       = 8'h01;
	localparam logic [7:0] CMD_ENTRY_BASE  = 8'h04;
	localparam logic [7:0] CMD_DDRAM_LINE1 = 8'h80;
	localparam logic [7:0] CMD_DDRAM_LINE2 = 8'hC0;

	// configuration word {lines, font, on, cursor, blink, increment, shift}
	localparam int CFG_W      = 7;
	localparam int CFG_LINES  = 6;
	localparam int CFG_FONT   = 5;
	localparam int CFG_ON     = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK  = 2;
	localparam int CFG_INC    = 1;
	localparam int CFG_SHIFT  = 0;

	// buffer and bus word
	localparam int LINE_CHARS  = 16;
	localparam int NUM_CHARS   = 2 * LINE_CHARS;
	localparam int CHAR_ADDR_W = $clog2(NUM_CHARS);
	localparam int NUM_WRITES  = NUM_CHARS + 2;   // plus two address commands
	localparam int POS_W       = $clog2(NUM_WRITES);
	localparam int BUS_W       = 10;              // {rs, rw, data}
	localparam logic [7:0] CHAR_SPACE = 8'h20;

	typedef logic [CHAR_ADDR_W-1:0] char_addr_t;
	typedef logic [BUS_W-1:0]       lcd_word_t;
	typedef logic [POS_W-1:0]       seq_pos_t;

endpackage
